// ==== rtl/lc3_pkg.sv ====
package lc3_pkg;

  typedef logic [15:0] word_t;
  typedef logic [2:0]  reg_idx_t;

  // Opcodes at their LC-3 encodings, 1101 reused as HALT
  typedef enum logic [3:0] {
    OP_BR   = 4'b0000,
    OP_ADD  = 4'b0001,
    OP_LD   = 4'b0010,
    OP_ST   = 4'b0011,
    OP_JSR  = 4'b0100,
    OP_AND  = 4'b0101,
    OP_LDR  = 4'b0110,
    OP_STR  = 4'b0111,
    OP_NOT  = 4'b1001,
    OP_JMP  = 4'b1100,
    OP_HALT = 4'b1101,
    OP_LEA  = 4'b1110
  } opcode_e;

  // Bus source
  typedef enum logic [1:0] {
    GATE_PC     = 2'd0,
    GATE_MDR    = 2'd1,
    GATE_ALU    = 2'd2,
    GATE_MARMUX = 2'd3
  } gate_e;

  typedef enum logic [1:0] {
    PC_INC   = 2'd0, // PC + 1
    PC_BUS   = 2'd1,
    PC_ADDER = 2'd2  // Address adder result
  } pcmux_e;

  typedef enum logic [1:0] {
    ADDR2_ZERO  = 2'd0,
    ADDR2_OFF6  = 2'd1,
    ADDR2_OFF9  = 2'd2,
    ADDR2_OFF11 = 2'd3
  } addr2_e;

  typedef enum logic [1:0] {
    ALU_ADD   = 2'd0,
    ALU_AND   = 2'd1,
    ALU_NOT   = 2'd2,
    ALU_PASSA = 2'd3
  } aluk_e;

  // Everything control hands to the datapath in one cycle
  typedef struct packed {
    logic   ld_ir;
    logic   ld_mdr;
    logic   ld_mar;
    logic   ld_pc;
    logic   ld_reg;
    logic   ld_cc;
    logic   ld_ben;
    gate_e  gate;
    pcmux_e pcmux;
    logic   addr1_sr1;   // SR1 instead of PC into the adder
    addr2_e addr2;
    logic   sr1_from_dr; // SR1 from IR[11:9], used by stores
    logic   dr_r7;
    logic   sr2_imm;
    aluk_e  aluk;
    logic   mio_en;      // MDR from memory instead of bus
  } ctrl_t;

  typedef struct packed {
    word_t addr;
    word_t wdata;
    logic  we;
  } mem_req_t;

endpackage

// ==== rtl/lc3_alu.sv ====
`timescale 1ns/1ps

module lc3_alu import lc3_pkg::*; (
  input  word_t a,
  input  word_t b,
  input  aluk_e aluk,
  output word_t result
);

  always_comb begin
    result = a; // Pass-A unless overridden
    unique case (aluk)
      ALU_ADD:   result = a + b;
      ALU_AND:   result = a & b;
      ALU_NOT:   result = ~a;
      ALU_PASSA: result = a;
    endcase
  end

  // Operation select must settle to a real encoding
  always_comb begin
    assert final (!$isunknown(aluk))
      else $error("lc3_alu: aluk is unknown");
  end

endmodule

// ==== rtl/lc3_regfile.sv ====
`timescale 1ns/1ps

module lc3_regfile import lc3_pkg::*; (
  input  logic     Clk,
  input  logic     arst_n,
  input  logic     we,
  input  reg_idx_t dr,
  input  reg_idx_t sr1,
  input  reg_idx_t sr2,
  input  word_t    wdata,
  output word_t    sr1_data,
  output word_t    sr2_data
);

  word_t regs [8];

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 8; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[dr] <= wdata;
    end
  end

  // Read ports see the value before this cycle's write
  assign sr1_data = regs[sr1];
  assign sr2_data = regs[sr2];

  // Nothing unknown gets written into the register file
  a_wdata_known: assert property (
    @(posedge Clk) disable iff (!arst_n)
    we |-> !$isunknown(wdata)
  ) else $error("lc3_regfile: write of unknown data to R%0d", dr);

endmodule

// ==== rtl/lc3_datapath.sv ====
`timescale 1ns/1ps

module lc3_datapath import lc3_pkg::*; #(
  parameter word_t RESET_PC = 16'h3000
) (
  input  logic  Clk,
  input  logic  arst_n,
  input  ctrl_t ctrl,
  input  word_t mem_rdata,
  input  logic  mem_rsp_valid,
  output word_t mar,
  output word_t mdr,
  output word_t ir,
  output word_t pc,
  output logic  ben
);

  word_t    bus;
  word_t    pc_next;
  word_t    mdr_next;
  word_t    addr1, addr2, adder_out;
  word_t    sext5, sext6, sext9, sext11;
  word_t    sr1_data, sr2_data, alu_b, alu_out;
  reg_idx_t sr1_idx, dr_idx;
  logic [2:0] nzp;

  // Sign extended IR fields
  assign sext5  = {{11{ir[4]}}, ir[4:0]};
  assign sext6  = {{10{ir[5]}}, ir[5:0]};
  assign sext9  = {{7{ir[8]}}, ir[8:0]};
  assign sext11 = {{5{ir[10]}}, ir[10:0]};

  assign sr1_idx = ctrl.sr1_from_dr ? ir[11:9] : ir[8:6];
  assign dr_idx  = ctrl.dr_r7 ? 3'd7 : ir[11:9];
  assign alu_b   = ctrl.sr2_imm ? sext5 : sr2_data;

  // Address adder
  assign addr1 = ctrl.addr1_sr1 ? sr1_data : pc;
  always_comb begin
    unique case (ctrl.addr2)
      ADDR2_ZERO:  addr2 = '0;
      ADDR2_OFF6:  addr2 = sext6;
      ADDR2_OFF9:  addr2 = sext9;
      ADDR2_OFF11: addr2 = sext11;
    endcase
  end
  assign adder_out = addr1 + addr2;

  // Single bus, one source at a time
  always_comb begin
    unique case (ctrl.gate)
      GATE_PC:     bus = pc;
      GATE_MDR:    bus = mdr;
      GATE_ALU:    bus = alu_out;
      GATE_MARMUX: bus = adder_out;
    endcase
  end

  always_comb begin
    pc_next = pc + 16'd1;
    unique case (ctrl.pcmux)
      PC_BUS:   pc_next = bus;
      PC_ADDER: pc_next = adder_out;
      default:  pc_next = pc + 16'd1;
    endcase
  end

  assign mdr_next = ctrl.mio_en ? mem_rdata : bus;

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      pc  <= RESET_PC;
      ir  <= '0;
      nzp <= 3'b010; // Z after reset
      ben <= 1'b0;
    end else begin
      if (ctrl.ld_pc) pc <= pc_next;
      if (ctrl.ld_ir) ir <= bus;
      if (ctrl.ld_cc) begin
        nzp <= {bus[15], bus == 16'd0, !bus[15] && bus != 16'd0};
      end
      if (ctrl.ld_ben) ben <= |(ir[11:9] & nzp);
    end
  end

  // Address and data holding registers
  always_ff @(posedge Clk) begin
    if (ctrl.ld_mar) mar <= bus;
    if (ctrl.ld_mdr) mdr <= mdr_next;
  end

  lc3_regfile u_regfile (
    .Clk      (Clk),
    .arst_n   (arst_n),
    .we       (ctrl.ld_reg),
    .dr       (dr_idx),
    .sr1      (sr1_idx),
    .sr2      (ir[2:0]),
    .wdata    (bus),
    .sr1_data (sr1_data),
    .sr2_data (sr2_data)
  );

  lc3_alu u_alu (
    .a      (sr1_data),
    .b      (alu_b),
    .aluk   (ctrl.aluk),
    .result (alu_out)
  );

  // Control must only capture read data in the response cycle
  a_mdr_from_rsp: assert property (
    @(posedge Clk) disable iff (!arst_n)
    (ctrl.ld_mdr && ctrl.mio_en) |-> mem_rsp_valid
  ) else $error("lc3_datapath: MDR loaded from memory without a response");

endmodule

// ==== rtl/lc3_control.sv ====
`timescale 1ns/1ps

module lc3_control import lc3_pkg::*; (
  input  logic  Clk,
  input  logic  arst_n,
  input  word_t ir,
  input  logic  ben,
  input  logic  mem_req_ready,
  input  logic  mem_rsp_valid,
  output ctrl_t ctrl,
  output logic  mem_req_valid,
  output logic  mem_we,
  output logic  halted,
  output logic  illegal
);

  typedef enum logic [4:0] {
    S_F1, S_F2, S_F3, S_F4, S_DECODE,
    S_ADD, S_AND, S_NOT, S_LEA, S_BR, S_JMP, S_JSR1, S_JSR2,
    S_LD_MAR, S_LD_REQ, S_LD_WAIT, S_LD_REG,
    S_ST_MAR, S_ST_MDR, S_ST_REQ,
    S_HALT
  } state_e;

  state_e  state, state_next, dec_state;
  opcode_e op;
  logic    op_legal;

  assign op = opcode_e'(ir[15:12]);

  // Execute entry point per opcode
  always_comb begin
    dec_state = S_HALT;
    op_legal  = 1'b1;
    case (op)
      OP_BR:         dec_state = S_BR;
      OP_ADD:        dec_state = S_ADD;
      OP_AND:        dec_state = S_AND;
      OP_NOT:        dec_state = S_NOT;
      OP_JMP:        dec_state = S_JMP;
      OP_JSR:        dec_state = S_JSR1;
      OP_LD, OP_LDR: dec_state = S_LD_MAR;
      OP_ST, OP_STR: dec_state = S_ST_MAR;
      OP_LEA:        dec_state = S_LEA;
      OP_HALT:       dec_state = S_HALT;
      default:       op_legal = 1'b0; // LDI, STI, RTI, TRAP
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      S_F1:      state_next = S_F2;
      S_F2:      if (mem_req_ready) state_next = S_F3;
      S_F3:      if (mem_rsp_valid) state_next = S_F4;
      S_F4:      state_next = S_DECODE;
      S_DECODE:  state_next = dec_state;
      S_JSR1:    state_next = S_JSR2;
      S_LD_MAR:  state_next = S_LD_REQ;
      S_LD_REQ:  if (mem_req_ready) state_next = S_LD_WAIT;
      S_LD_WAIT: if (mem_rsp_valid) state_next = S_LD_REG;
      S_ST_MAR:  state_next = S_ST_MDR;
      S_ST_MDR:  state_next = S_ST_REQ;
      S_ST_REQ:  if (mem_req_ready) state_next = S_F1; // Write done at transfer
      S_HALT:    state_next = S_HALT;
      default:   state_next = S_F1; // One-cycle execute states
    endcase
  end

  always_ff @(posedge Clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= S_F1;
      illegal <= 1'b0;
    end else begin
      state <= state_next;
      if (state == S_DECODE && !op_legal) illegal <= 1'b1;
    end
  end

  assign halted = (state == S_HALT);

  // Control word from the state, with IR fields picking operands
  always_comb begin
    ctrl          = '0;
    mem_req_valid = 1'b0;
    mem_we        = 1'b0;
    case (state)
      S_F1: begin
        ctrl.gate   = GATE_PC;
        ctrl.ld_mar = 1'b1;
        ctrl.pcmux  = PC_INC;
        ctrl.ld_pc  = 1'b1;
      end
      S_F2, S_LD_REQ: mem_req_valid = 1'b1;
      S_F3, S_LD_WAIT: begin
        ctrl.mio_en = 1'b1;
        ctrl.ld_mdr = mem_rsp_valid;
      end
      S_F4: begin
        ctrl.gate  = GATE_MDR;
        ctrl.ld_ir = 1'b1;
      end
      S_DECODE: ctrl.ld_ben = 1'b1;
      S_ADD, S_AND, S_NOT: begin
        ctrl.gate    = GATE_ALU;
        ctrl.aluk    = (state == S_ADD) ? ALU_ADD : (state == S_AND) ? ALU_AND : ALU_NOT;
        ctrl.sr2_imm = ir[5];
        ctrl.ld_reg  = 1'b1;
        ctrl.ld_cc   = 1'b1;
      end
      S_LEA: begin
        ctrl.gate   = GATE_MARMUX;
        ctrl.addr2  = ADDR2_OFF9;
        ctrl.ld_reg = 1'b1;
        ctrl.ld_cc  = 1'b1;
      end
      S_BR: begin
        ctrl.pcmux = PC_ADDER;
        ctrl.addr2 = ADDR2_OFF9;
        ctrl.ld_pc = ben; // Only on a taken branch
      end
      S_JMP: begin
        ctrl.pcmux     = PC_ADDER;
        ctrl.addr1_sr1 = 1'b1;
        ctrl.addr2     = ADDR2_ZERO;
        ctrl.ld_pc     = 1'b1;
      end
      S_JSR1: begin
        ctrl.gate   = GATE_PC;
        ctrl.dr_r7  = 1'b1;
        ctrl.ld_reg = 1'b1;
      end
      S_JSR2: begin
        ctrl.pcmux     = PC_ADDER;
        ctrl.addr1_sr1 = !ir[11];                        // JSRR uses BaseR
        ctrl.addr2     = ir[11] ? ADDR2_OFF11 : ADDR2_ZERO;
        ctrl.ld_pc     = 1'b1;
      end
      S_LD_MAR, S_ST_MAR: begin
        ctrl.gate      = GATE_MARMUX;
        ctrl.addr1_sr1 = (op == OP_LDR) || (op == OP_STR);
        ctrl.addr2     = ctrl.addr1_sr1 ? ADDR2_OFF6 : ADDR2_OFF9;
        ctrl.ld_mar    = 1'b1;
      end
      S_LD_REG: begin
        ctrl.gate   = GATE_MDR;
        ctrl.ld_reg = 1'b1;
        ctrl.ld_cc  = 1'b1;
      end
      S_ST_MDR: begin
        ctrl.gate        = GATE_ALU;
        ctrl.aluk        = ALU_PASSA;
        ctrl.sr1_from_dr = 1'b1;
        ctrl.ld_mdr      = 1'b1;
      end
      S_ST_REQ: begin
        mem_req_valid = 1'b1;
        mem_we        = 1'b1;
      end
      default: ;
    endcase
  end

  // Request held until accepted
  a_req_hold: assert property (
    @(posedge Clk) disable iff (!arst_n)
    (mem_req_valid && !mem_req_ready) |=> (mem_req_valid && $stable(mem_we))
  ) else $error("lc3_control: request dropped before ready");

  a_state_known: assert property (
    @(posedge Clk) disable iff (!arst_n)
    !$isunknown(state)
  ) else $error("lc3_control: state is unknown");

endmodule

// ==== rtl/lc3_core.sv ====
`timescale 1ns/1ps

module lc3_core import lc3_pkg::*; #(
  parameter word_t RESET_PC = 16'h3000
) (
  input  logic     Clk,
  input  logic     arst_n,
  output mem_req_t mem_req,
  output logic     mem_req_valid,
  input  logic     mem_req_ready,
  input  logic     mem_rsp_valid,
  input  word_t    mem_rdata,
  output word_t    pc,
  output logic     halted,
  output logic     illegal
);

  ctrl_t ctrl;
  word_t ir;
  word_t mar;
  word_t mdr;
  logic  ben;
  logic  mem_we;

  lc3_control u_control (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .ir            (ir),
    .ben           (ben),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .ctrl          (ctrl),
    .mem_req_valid (mem_req_valid),
    .mem_we        (mem_we),
    .halted        (halted),
    .illegal       (illegal)
  );

  lc3_datapath #(.RESET_PC(RESET_PC)) u_datapath (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .ctrl          (ctrl),
    .mem_rdata     (mem_rdata),
    .mem_rsp_valid (mem_rsp_valid),
    .mar           (mar),
    .mdr           (mdr),
    .ir            (ir),
    .pc            (pc),
    .ben           (ben)
  );

  // Address from MAR, store data from MDR
  assign mem_req.addr  = mar;
  assign mem_req.wdata = mdr;
  assign mem_req.we    = mem_we;

endmodule

// ==== test/tb_lc3.sv ====
`timescale 1ns/1ps

module tb_lc3 import lc3_pkg::*; ();

  localparam word_t START      = 16'h3000;
  localparam int    NUM_TESTS  = 7;
  localparam int    MAX_PROG   = 40;             // Longest program in words
  localparam int    HALT_LIMIT = 200 * MAX_PROG;

  logic     Clk;
  logic     arst_n;
  mem_req_t mem_req;
  logic     mem_req_valid;
  logic     mem_req_ready;
  logic     mem_rsp_valid;
  word_t    mem_rdata;
  word_t    pc;
  logic     halted;
  logic     illegal;

  word_t      mem [0:65535];
  word_t      load_ptr;
  word_t      lfsr = 16'd8;
  logic       bp_mode;                           // Random ready and read delay
  logic       pending;
  logic [1:0] rd_wait;
  word_t      rd_addr;
  logic       seen_first;
  word_t      first_addr;
  int         req_seen;
  mem_req_t   exp_stores [$];
  int         value_errors;
  int         other_errors;

  lc3_core #(.RESET_PC(START)) UUT (
    .Clk           (Clk),
    .arst_n        (arst_n),
    .mem_req       (mem_req),
    .mem_req_valid (mem_req_valid),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rdata     (mem_rdata),
    .pc            (pc),
    .halted        (halted),
    .illegal       (illegal)
  );

  initial begin
    Clk = 1'b0;
    forever #5 Clk = ~Clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic word_t lfsr_next(word_t s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic take_bit();
    lfsr = lfsr_next(lfsr);
    return lfsr[0];
  endfunction

  // Instruction encoders for the LC-3 formats
  function automatic word_t enc_rr(opcode_e op, reg_idx_t dr, reg_idx_t sr1, reg_idx_t sr2);
    return {op, dr, sr1, 3'b000, sr2};
  endfunction

  function automatic word_t enc_imm(opcode_e op, reg_idx_t dr, reg_idx_t sr1, int imm);
    return {op, dr, sr1, 1'b1, imm[4:0]};
  endfunction

  // Offset relative to the slot at load_ptr
  function automatic word_t enc_pc9(opcode_e op, reg_idx_t r, word_t target);
    word_t off;
    off = target - load_ptr - 16'd1;
    return {op, r, off[8:0]};
  endfunction

  function automatic word_t enc_base6(opcode_e op, reg_idx_t r, reg_idx_t base, int off6);
    return {op, r, base, off6[5:0]};
  endfunction

  task automatic emit(word_t w);
    mem[load_ptr] = w;
    load_ptr = load_ptr + 16'd1;
  endtask

  task automatic expect_store(word_t addr, word_t data);
    mem_req_t r;
    r.addr  = addr;
    r.wdata = data;
    r.we    = 1'b1;
    exp_stores.push_back(r);
  endtask

  task automatic new_program(logic bp);
    for (int i = 0; i < 65536; i++) begin
      mem[i[15:0]] = ~i[15:0];
    end
    load_ptr = START;
    exp_stores.delete();
    bp_mode = bp;
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t ns: %s = %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_req(mem_req_t got, mem_req_t exp);
    if (got !== exp) begin
      value_errors++;
      $display("ERROR at %0t ns: mem_req = {addr %h, wdata %h, we %b}, expected {%h, %h, %b}",
               $time, got.addr, got.wdata, got.we, exp.addr, exp.wdata, exp.we);
    end
  endtask

  // Memory model driving its outputs on the falling edge
  always @(negedge Clk) begin
    mem_rsp_valid = 1'b0;
    if (!arst_n) begin
      pending       = 1'b0;
      mem_req_ready = 1'b0;
    end else begin
      if (pending) begin
        if (rd_wait == 2'd0) begin
          mem_rsp_valid = 1'b1;
          mem_rdata     = mem[rd_addr];
          pending       = 1'b0;
        end else begin
          rd_wait = rd_wait - 2'd1;
        end
      end
      if (mem_req_valid) req_seen++;
      mem_req_ready = bp_mode ? take_bit() : 1'b1;
      if (mem_req_valid && mem_req_ready) begin  // Transfer on the coming rising edge
        if (mem_req.we) begin
          if (exp_stores.size() == 0) begin
            other_errors++;
            $display("Unexpected store of %h to address %h", mem_req.wdata, mem_req.addr);
          end else begin
            check_req(mem_req, exp_stores.pop_front());
          end
          mem[mem_req.addr] = mem_req.wdata;
        end else begin
          if (!seen_first) begin
            first_addr = mem_req.addr;
            seen_first = 1'b1;
          end
          rd_addr = mem_req.addr;
          pending = 1'b1;
          rd_wait = 2'd0;
          if (bp_mode) begin
            rd_wait[1] = take_bit();
            rd_wait[0] = take_bit();
          end
        end
      end
    end
  end

  task automatic pulse_reset();
    @(negedge Clk);
    arst_n     = 1'b0;
    seen_first = 1'b0;
    repeat (2) @(negedge Clk);
    check_word("pc", pc, START);
    check_flag("mem_req_valid", mem_req_valid, 1'b0);
    check_flag("halted", halted, 1'b0);
    check_flag("illegal", illegal, 1'b0);
    arst_n = 1'b1;
  endtask

  task automatic run_program(string name);
    int cycles;
    pulse_reset();
    cycles = 0;
    while (!halted && cycles < HALT_LIMIT) begin
      @(negedge Clk);
      cycles++;
    end
    if (!halted) begin
      other_errors++;
      $display("%s program did not halt within %0d cycles", name, HALT_LIMIT);
    end
    if (exp_stores.size() != 0) begin
      other_errors++;
      $display("%s program never made %0d of its stores", name, exp_stores.size());
      exp_stores.delete();
    end
  endtask

  task automatic test_alu(logic bp);
    word_t a;
    word_t b;
    word_t res [5];
    a      = 16'h7FF3;
    b      = 16'h0025;
    res[0] = a + b;        // Wraps past 7FFF
    res[1] = a + 16'hFFF9; // Immediate -7 sign extended
    res[2] = a & b;
    res[3] = b & 16'h000D;
    res[4] = ~a;
    new_program(bp);
    mem[16'h3040] = a;
    mem[16'h3041] = b;
    emit(enc_pc9(OP_LD, 1, 16'h3040));
    emit(enc_pc9(OP_LD, 2, 16'h3041));
    emit(enc_rr(OP_ADD, 3, 1, 2));
    emit(enc_imm(OP_ADD, 4, 1, -7));
    emit(enc_rr(OP_AND, 5, 1, 2));
    emit(enc_imm(OP_AND, 6, 2, 13));
    emit({OP_NOT, 3'd7, 3'd1, 6'h3F});
    for (int i = 0; i < 5; i++) begin
      emit(enc_pc9(OP_ST, reg_idx_t'(i + 3), 16'h3050 + word_t'(i)));
      expect_store(16'h3050 + word_t'(i), res[i]);
    end
    emit({OP_HALT, 12'd0});
    run_program("ALU");
    for (int i = 0; i < 5; i++) begin
      check_word($sformatf("mem[%h]", 16'h3050 + word_t'(i)), mem[16'h3050 + word_t'(i)], res[i]);
    end
    check_word("pc", pc, load_ptr);
  endtask

  task automatic test_branch(logic bp);
    int         imm [6]  = '{-8, -8, -5, -5, 3, 3};
    logic [2:0] mask [6] = '{3'b100, 3'b010, 3'b010, 3'b101, 3'b100, 3'b001};
    word_t      flag [6];
    word_t      count;
    word_t      loop_at;
    word_t      v;
    logic       taken;
    count = 16'd5;
    new_program(bp);
    mem[16'h3040] = count;
    emit(enc_pc9(OP_LD, 1, 16'h3040));
    emit(enc_imm(OP_AND, 2, 2, 0));
    loop_at = load_ptr;
    emit(enc_imm(OP_ADD, 2, 2, 1));
    emit(enc_imm(OP_ADD, 1, 1, -1));
    emit(enc_pc9(OP_BR, 3'b001, loop_at)); // BRp until R1 reaches zero
    emit(enc_pc9(OP_ST, 2, 16'h3050));
    expect_store(16'h3050, count);
    for (int k = 0; k < 6; k++) begin
      v       = count + word_t'(imm[k]);
      taken   = (mask[k][2] && $signed(v) < 0) || (mask[k][1] && v == 16'd0) ||
                (mask[k][0] && $signed(v) > 0);
      flag[k] = taken ? 16'd0 : 16'd1;
      emit(enc_imm(OP_AND, 4, 4, 0));
      emit(enc_imm(OP_ADD, 3, 2, imm[k]));
      emit(enc_pc9(OP_BR, mask[k], load_ptr + 16'd2));
      emit(enc_imm(OP_ADD, 4, 4, 1));
      emit(enc_pc9(OP_ST, 4, 16'h3051 + word_t'(k)));
      expect_store(16'h3051 + word_t'(k), flag[k]);
    end
    emit({OP_HALT, 12'd0});
    run_program("branch");
    check_word("loop count", mem[16'h3050], count);
    for (int k = 0; k < 6; k++) begin
      check_word($sformatf("branch flag %0d", k), mem[16'h3051 + word_t'(k)], flag[k]);
    end
    check_word("pc", pc, load_ptr);
  endtask

  task automatic test_addressing();
    word_t tbl [4];
    word_t lea_val;
    word_t jsr_at;
    word_t jsrr_at;
    word_t halt_next;
    word_t off;
    tbl = '{16'h1234, 16'h0F0F, 16'hA5A5, 16'h7777};
    new_program(1'b0);
    emit(enc_pc9(OP_BR, 3'b111, START + 16'd5)); // Jump over the table
    for (int i = 0; i < 4; i++) begin
      emit(tbl[i]);
    end
    lea_val = START + 16'd4;                      // Last table word just before the LEA
    emit(enc_pc9(OP_LEA, 1, lea_val));
    emit(enc_base6(OP_LDR, 2, 1, -3));
    emit(enc_base6(OP_LDR, 3, 1, -1));
    emit(enc_rr(OP_ADD, 4, 2, 3));
    emit(enc_base6(OP_STR, 4, 1, -2));
    emit(enc_pc9(OP_ST, 1, 16'h3040));
    jsr_at = load_ptr;
    off    = 16'h3020 - jsr_at - 16'd1;
    emit({OP_JSR, 1'b1, off[10:0]});
    emit(enc_pc9(OP_ST, 7, 16'h3041));
    emit(enc_pc9(OP_LEA, 5, 16'h3028));
    jsrr_at = load_ptr;
    emit({OP_JSR, 3'b000, 3'd5, 6'd0});           // JSRR R5
    emit(enc_pc9(OP_ST, 7, 16'h3042));
    emit({OP_HALT, 12'd0});
    halt_next = load_ptr;
    load_ptr  = 16'h3020;
    emit(enc_pc9(OP_ST, 7, 16'h3043));
    emit({OP_JMP, 3'd0, 3'd7, 6'd0});             // RET
    load_ptr = 16'h3028;
    emit(enc_pc9(OP_ST, 7, 16'h3044));
    emit({OP_JMP, 3'd0, 3'd7, 6'd0});
    // Stores in execution order
    expect_store(lea_val - 16'd2, tbl[0] + tbl[2]);
    expect_store(16'h3040, lea_val);
    expect_store(16'h3043, jsr_at + 16'd1);
    expect_store(16'h3041, jsr_at + 16'd1);
    expect_store(16'h3044, jsrr_at + 16'd1);
    expect_store(16'h3042, jsrr_at + 16'd1);
    run_program("addressing");
    check_word("STR target", mem[lea_val - 16'd2], tbl[0] + tbl[2]);
    check_word("LEA result", mem[16'h3040], lea_val);
    check_word("R7 after JSR", mem[16'h3041], jsr_at + 16'd1);
    check_word("R7 after JSRR", mem[16'h3042], jsrr_at + 16'd1);
    check_word("pc", pc, halt_next);
  endtask

  task automatic test_halt();
    word_t halt_at;
    int    seen;
    new_program(1'b0);
    emit(enc_imm(OP_ADD, 1, 1, 1));
    halt_at = load_ptr;
    emit({OP_HALT, 12'd0});
    run_program("HALT");
    check_word("first fetch address", first_addr, START);
    check_word("pc", pc, halt_at + 16'd1);
    check_flag("illegal", illegal, 1'b0);
    seen = req_seen;
    repeat (50) @(negedge Clk);
    if (req_seen != seen) begin
      other_errors++;
      $display("Core made %0d request cycles after HALT", req_seen - seen);
    end
    check_flag("halted", halted, 1'b1);
  endtask

  task automatic test_illegal();
    new_program(1'b0);
    emit(16'hF025); // TRAP, not in the subset
    run_program("illegal opcode");
    check_flag("illegal", illegal, 1'b1);
    check_word("pc", pc, START + 16'd1);
  endtask

  initial begin
    arst_n        = 1'b0;
    mem_req_ready = 1'b0;
    mem_rsp_valid = 1'b0;
    mem_rdata     = '0;
    bp_mode       = 1'b0;
    pending       = 1'b0;
    rd_wait       = 2'd0;
    rd_addr       = '0;
    seen_first    = 1'b0;
    first_addr    = '0;
    req_seen      = 0;
    value_errors  = 0;
    other_errors  = 0;
    test_alu(1'b0);
    test_branch(1'b0);
    test_addressing();
    test_alu(1'b1);    // Same programs under back-pressure
    test_branch(1'b1);
    test_halt();
    test_illegal();
    $display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    repeat (HALT_LIMIT * NUM_TESTS) @(posedge Clk);
    $display("Watchdog expired after %0d cycles, core is stuck", HALT_LIMIT * NUM_TESTS);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== list.f ====
rtl/lc3_pkg.sv
rtl/lc3_alu.sv
rtl/lc3_regfile.sv
rtl/lc3_datapath.sv
rtl/lc3_control.sv
rtl/lc3_core.sv
test/tb_lc3.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_lc3
FILELIST = list.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
